/* yuv_mem_pkg.sv */
package yuv_mem_pkg;

	// SRAM geometry
	localparam int ADDR_W = 18;
	localparam int DATA_W = 16;

	// cycles from address to read data
	localparam int SRAM_RD_LAT = 2;

	// configuration register map
	localparam int CFG_ADDR_W = 2;

	localparam logic [CFG_ADDR_W-1:0] REG_Y_BASE   = 2'd0;
	localparam logic [CFG_ADDR_W-1:0] REG_U_BASE   = 2'd1;
	localparam logic [CFG_ADDR_W-1:0] REG_V_BASE   = 2'd2;
	localparam logic [CFG_ADDR_W-1:0] REG_RGB_BASE = 2'd3;

endpackage

/* yuv_color_pkg.sv */
package yuv_color_pkg;

	localparam int PIX_W   = 8;
	localparam int PROD_W  = 32;
	localparam int PIX_MAX = 255;

	// six-tap interpolation, symmetric, taps sum to 256
	localparam int TAP_0      = 21;
	localparam int TAP_1      = -52;
	localparam int TAP_2      = 159;
	localparam int FILT_SHIFT = 8;
	localparam int FILT_ROUND = 128;

	// YUV to RGB in 16.16 fixed point
	localparam int C_Y       = 76284;
	localparam int C_RV      = 104595;
	localparam int C_GU      = 25624;
	localparam int C_GV      = 53281;
	localparam int C_BU      = 132251;
	localparam int CSC_SHIFT = 16;
	localparam int Y_OFFSET  = 16;
	localparam int UV_OFFSET = 128;

	function automatic logic [PIX_W-1:0] clip_pix(input logic signed [PROD_W-1:0] val);
		if (val < 0)
			return '0;
		else if (val > PIX_MAX)
			return '1;
		else
			return val[PIX_W-1:0];
	endfunction

endpackage

/* yuv_regs.sv */
`timescale 1ns/1ps

module yuv_regs
	import yuv_mem_pkg::*;
#(
	parameter int IMG_WIDTH  = 12,
	parameter int IMG_HEIGHT = 2
) (
	input  logic                  Clock,
	input  logic                  Resetn,
	input  logic                  cfg_write,
	input  logic [CFG_ADDR_W-1:0] cfg_addr,
	input  logic [ADDR_W-1:0]     cfg_wdata,
	input  logic                  start,
	input  logic                  frame_end,
	output logic [ADDR_W-1:0]     cfg_rdata,
	output logic [ADDR_W-1:0]     y_base,
	output logic [ADDR_W-1:0]     u_base,
	output logic [ADDR_W-1:0]     v_base,
	output logic [ADDR_W-1:0]     rgb_base,
	output logic                  run,
	output logic                  busy,
	output logic                  done
);

	localparam int RGB_WORDS = IMG_WIDTH * 3 / 2 * IMG_HEIGHT;

	// first address past the RGB region of one frame
	logic [ADDR_W-1:0] rgb_end;

	assign rgb_end = rgb_base + ADDR_W'(RGB_WORDS);

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			y_base   <= '0;
			u_base   <= '0;
			v_base   <= '0;
			rgb_base <= '0;
		end else if (cfg_write) begin
			case (cfg_addr)
				REG_Y_BASE:   y_base   <= cfg_wdata;
				REG_U_BASE:   u_base   <= cfg_wdata;
				REG_V_BASE:   v_base   <= cfg_wdata;
				REG_RGB_BASE: rgb_base <= cfg_wdata;
				default: ;
			endcase
		end
	end

	always_comb begin
		case (cfg_addr)
			REG_Y_BASE:   cfg_rdata = y_base;
			REG_U_BASE:   cfg_rdata = u_base;
			REG_V_BASE:   cfg_rdata = v_base;
			default:      cfg_rdata = rgb_base;
		endcase
	end

	// start is dropped while a frame runs
	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			run  <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			run  <= start && !busy;
			done <= frame_end;
			if (start && !busy)
				busy <= 1'b1;
			else if (frame_end)
				busy <= 1'b0;
		end
	end

endmodule

/* chroma_upsampler.sv */
`timescale 1ns/1ps

module chroma_upsampler
	import yuv_color_pkg::*;
(
	input  logic             Clock,
	input  logic             Resetn,
	input  logic             prime,
	input  logic             push,
	input  logic [PIX_W-1:0] sample_in,
	output logic [PIX_W-1:0] even_out,
	output logic [PIX_W-1:0] odd_out
);

	// win[0] is sample k-2, win[5] is sample k+3
	logic [PIX_W-1:0] win [6];
	logic [PIX_W-1:0] win_nx [6];
	logic signed [PROD_W-1:0] acc;

	always_comb begin
		for (int i = 0; i < 6; i++)
			win_nx[i] = win[i];
		if (prime) begin
			for (int i = 0; i < 6; i++)
				win_nx[i] = sample_in;
		end else if (push) begin
			for (int i = 0; i < 5; i++)
				win_nx[i] = win[i+1];
			win_nx[5] = sample_in;
		end
	end

	// filter runs on the updated window so outputs follow one cycle later
	always_comb begin
		acc = TAP_0 * ($signed(PROD_W'(win_nx[0])) + $signed(PROD_W'(win_nx[5])))
			+ TAP_1 * ($signed(PROD_W'(win_nx[1])) + $signed(PROD_W'(win_nx[4])))
			+ TAP_2 * ($signed(PROD_W'(win_nx[2])) + $signed(PROD_W'(win_nx[3])))
			+ FILT_ROUND;
	end

	always_ff @(posedge Clock) begin
		for (int i = 0; i < 6; i++)
			win[i] <= win_nx[i];
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			even_out <= '0;
			odd_out  <= '0;
		end else begin
			even_out <= win_nx[2];
			odd_out  <= clip_pix(acc >>> FILT_SHIFT);
		end
	end

endmodule

/* csc_unit.sv */
`timescale 1ns/1ps

module csc_unit
	import yuv_color_pkg::*;
(
	input  logic             Clock,
	input  logic             Resetn,
	input  logic             conv_in_valid,
	input  logic [PIX_W-1:0] y_in,
	input  logic [PIX_W-1:0] u_in,
	input  logic [PIX_W-1:0] v_in,
	output logic [PIX_W-1:0] r_out,
	output logic [PIX_W-1:0] g_out,
	output logic [PIX_W-1:0] b_out,
	output logic             conv_out_valid
);

	logic signed [PROD_W-1:0] y_m;
	logic signed [PROD_W-1:0] u_m;
	logic signed [PROD_W-1:0] v_m;

	// stage 1 products
	logic signed [PROD_W-1:0] p_y;
	logic signed [PROD_W-1:0] p_rv;
	logic signed [PROD_W-1:0] p_gu;
	logic signed [PROD_W-1:0] p_gv;
	logic signed [PROD_W-1:0] p_bu;
	logic                     valid_s1;

	logic signed [PROD_W-1:0] sum_r;
	logic signed [PROD_W-1:0] sum_g;
	logic signed [PROD_W-1:0] sum_b;

	assign y_m = $signed(PROD_W'(y_in)) - Y_OFFSET;
	assign u_m = $signed(PROD_W'(u_in)) - UV_OFFSET;
	assign v_m = $signed(PROD_W'(v_in)) - UV_OFFSET;

	always_ff @(posedge Clock) begin
		p_y  <= C_Y * y_m;
		p_rv <= C_RV * v_m;
		p_gu <= C_GU * u_m;
		p_gv <= C_GV * v_m;
		p_bu <= C_BU * u_m;
	end

	assign sum_r = p_y + p_rv;
	assign sum_g = p_y - p_gu - p_gv;
	assign sum_b = p_y + p_bu;

	always_ff @(posedge Clock) begin
		r_out <= clip_pix(sum_r >>> CSC_SHIFT);
		g_out <= clip_pix(sum_g >>> CSC_SHIFT);
		b_out <= clip_pix(sum_b >>> CSC_SHIFT);
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			valid_s1       <= 1'b0;
			conv_out_valid <= 1'b0;
		end else begin
			valid_s1       <= conv_in_valid;
			conv_out_valid <= valid_s1;
		end
	end

endmodule

/* m1_sequencer.sv */
`timescale 1ns/1ps

module m1_sequencer
	import yuv_mem_pkg::*, yuv_color_pkg::*;
#(
	parameter int IMG_WIDTH  = 12,
	parameter int IMG_HEIGHT = 2
) (
	input  logic              Clock,
	input  logic              Resetn,
	input  logic              run,
	input  logic [ADDR_W-1:0] y_base,
	input  logic [ADDR_W-1:0] u_base,
	input  logic [ADDR_W-1:0] v_base,
	input  logic [ADDR_W-1:0] rgb_base,
	input  logic [DATA_W-1:0] sram_read_data,
	input  logic [PIX_W-1:0]  r_out,
	input  logic [PIX_W-1:0]  g_out,
	input  logic [PIX_W-1:0]  b_out,
	input  logic              conv_out_valid,
	input  logic [PIX_W-1:0]  u_even,
	input  logic [PIX_W-1:0]  u_odd,
	input  logic [PIX_W-1:0]  v_even,
	input  logic [PIX_W-1:0]  v_odd,
	output logic [ADDR_W-1:0] sram_address,
	output logic [DATA_W-1:0] sram_write_data,
	output logic              sram_we_n,
	output logic              frame_end,
	output logic              u_prime,
	output logic              u_push,
	output logic              v_prime,
	output logic              v_push,
	output logic [PIX_W-1:0]  chroma_sample_u,
	output logic [PIX_W-1:0]  chroma_sample_v,
	output logic              conv_in_valid,
	output logic [PIX_W-1:0]  y_in,
	output logic [PIX_W-1:0]  conv_u,
	output logic [PIX_W-1:0]  conv_v
);

	localparam int PAIRS = IMG_WIDTH / 2;
	localparam int K_W   = $clog2(PAIRS + 1);
	localparam int ROW_W = $clog2(IMG_HEIGHT + 1);

	localparam logic [1:0] KIND_NONE = 2'd0;
	localparam logic [1:0] KIND_Y    = 2'd1;
	localparam logic [1:0] KIND_U    = 2'd2;
	localparam logic [1:0] KIND_V    = 2'd3;

	typedef enum logic [3:0] {
		S_IDLE, S_RD_U, S_RD_V, S_WAIT_UV, S_PUSH_HI,
		S_PUSH_LO, S_RD_Y, S_WAIT_Y, S_CONV_E, S_CONV_O,
		S_WAIT_C, S_WR0, S_WR1, S_WR2, S_NEXT
	} seq_state_t;

	seq_state_t state;

	logic [ADDR_W-1:0] y_addr;
	logic [ADDR_W-1:0] u_addr;
	logic [ADDR_W-1:0] v_addr;
	logic [ADDR_W-1:0] w_addr;
	logic [K_W-1:0]    pair;
	logic [K_W-1:0]    pair_nx;
	logic [ROW_W-1:0]  row;
	logic              row_init;
	logic              init_word;
	logic              load_next;
	logic              fill_prime;
	logic              fill_push;

	// kind of read in flight per SRAM latency stage
	logic [1:0]        rd_kind;
	logic [1:0]        rd_pipe [SRAM_RD_LAT];
	logic              pipe_busy;

	logic [DATA_W-1:0] y_word;
	logic [DATA_W-1:0] u_word;
	logic [DATA_W-1:0] v_word;
	logic [PIX_W-1:0]  r0, g0, b0;
	logic [PIX_W-1:0]  r1, g1, b1;
	logic              res_odd;
	logic              pair_ready;

	// next pair needs a fresh chroma word while still inside the row
	assign pair_nx   = pair + 1'b1;
	assign load_next = pair_nx[0] && (int'(pair_nx) + 3 < PAIRS);

	always_comb begin
		rd_kind         = KIND_NONE;
		sram_address    = y_addr;
		sram_we_n       = 1'b1;
		sram_write_data = {r0, g0};
		case (state)
			S_RD_U: begin
				rd_kind      = KIND_U;
				sram_address = u_addr;
			end
			S_RD_V: begin
				rd_kind      = KIND_V;
				sram_address = v_addr;
			end
			S_RD_Y: rd_kind = KIND_Y;
			S_WR0: begin
				sram_address = w_addr;
				sram_we_n    = 1'b0;
			end
			S_WR1: begin
				sram_address    = w_addr;
				sram_we_n       = 1'b0;
				sram_write_data = {b0, r1};
			end
			S_WR2: begin
				sram_address    = w_addr;
				sram_we_n       = 1'b0;
				sram_write_data = {g1, b1};
			end
			default: ;
		endcase
		pipe_busy = 1'b0;
		for (int i = 0; i < SRAM_RD_LAT; i++)
			pipe_busy |= (rd_pipe[i] != KIND_NONE);
	end

	// first high byte of a row primes the windows
	assign fill_prime = (state == S_PUSH_HI) && row_init && !init_word;
	assign fill_push  = ((state == S_PUSH_HI) && !fill_prime) || (state == S_PUSH_LO);
	assign u_prime    = fill_prime;
	assign v_prime    = fill_prime;
	assign u_push     = fill_push;
	assign v_push     = fill_push;

	assign chroma_sample_u = (state == S_PUSH_HI) ? u_word[DATA_W-1:PIX_W] : u_word[PIX_W-1:0];
	assign chroma_sample_v = (state == S_PUSH_HI) ? v_word[DATA_W-1:PIX_W] : v_word[PIX_W-1:0];

	// even pixel first, odd pixel on the next cycle
	assign conv_in_valid = (state == S_CONV_E) || (state == S_CONV_O);
	assign y_in   = (state == S_CONV_O) ? y_word[PIX_W-1:0] : y_word[DATA_W-1:PIX_W];
	assign conv_u = (state == S_CONV_O) ? u_odd : u_even;
	assign conv_v = (state == S_CONV_O) ? v_odd : v_even;

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			for (int i = 0; i < SRAM_RD_LAT; i++)
				rd_pipe[i] <= KIND_NONE;
		end else begin
			rd_pipe[0] <= rd_kind;
			for (int i = 1; i < SRAM_RD_LAT; i++)
				rd_pipe[i] <= rd_pipe[i-1];
		end
	end

	always_ff @(posedge Clock) begin
		case (rd_pipe[SRAM_RD_LAT-1])
			KIND_Y: y_word <= sram_read_data;
			KIND_U: u_word <= sram_read_data;
			KIND_V: v_word <= sram_read_data;
			default: ;
		endcase
		if (conv_out_valid && !res_odd) begin
			r0 <= r_out;
			g0 <= g_out;
			b0 <= b_out;
		end
		if (conv_out_valid && res_odd) begin
			r1 <= r_out;
			g1 <= g_out;
			b1 <= b_out;
		end
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			state      <= S_IDLE;
			y_addr     <= '0;
			u_addr     <= '0;
			v_addr     <= '0;
			w_addr     <= '0;
			pair       <= '0;
			row        <= '0;
			row_init   <= 1'b0;
			init_word  <= 1'b0;
			res_odd    <= 1'b0;
			pair_ready <= 1'b0;
			frame_end  <= 1'b0;
		end else begin
			frame_end <= 1'b0;
			if (conv_out_valid) begin
				res_odd    <= !res_odd;
				pair_ready <= res_odd;
			end
			case (state)
				S_IDLE: begin
					if (run) begin
						y_addr    <= y_base;
						u_addr    <= u_base;
						v_addr    <= v_base;
						w_addr    <= rgb_base;
						pair      <= '0;
						row       <= '0;
						row_init  <= 1'b1;
						init_word <= 1'b0;
						state     <= S_RD_U;
					end
				end
				S_RD_U: begin
					u_addr <= u_addr + 1'b1;
					state  <= S_RD_V;
				end
				S_RD_V: begin
					v_addr <= v_addr + 1'b1;
					state  <= S_WAIT_UV;
				end
				S_WAIT_UV: if (!pipe_busy) state <= S_PUSH_HI;
				S_PUSH_HI: state <= row_init ? S_PUSH_LO : S_RD_Y;
				S_PUSH_LO: begin
					// row start loads chroma words 0 and 1
					if (row_init && !init_word) begin
						init_word <= 1'b1;
						state     <= S_RD_U;
					end else begin
						row_init <= 1'b0;
						state    <= S_RD_Y;
					end
				end
				S_RD_Y: begin
					y_addr <= y_addr + 1'b1;
					state  <= S_WAIT_Y;
				end
				S_WAIT_Y: if (!pipe_busy) state <= S_CONV_E;
				S_CONV_E: state <= S_CONV_O;
				S_CONV_O: state <= S_WAIT_C;
				S_WAIT_C: begin
					if (pair_ready) begin
						pair_ready <= 1'b0;
						state      <= S_WR0;
					end
				end
				S_WR0, S_WR1, S_WR2: begin
					w_addr <= w_addr + 1'b1;
					state  <= (state == S_WR2) ? S_NEXT : ((state == S_WR0) ? S_WR1 : S_WR2);
				end
				S_NEXT: begin
					if (int'(pair) == PAIRS - 1) begin
						pair <= '0;
						if (int'(row) == IMG_HEIGHT - 1) begin
							frame_end <= 1'b1;
							state     <= S_IDLE;
						end else begin
							row       <= row + 1'b1;
							row_init  <= 1'b1;
							init_word <= 1'b0;
							state     <= S_RD_U;
						end
					end else begin
						// past the row end the low byte repeats the last sample
						pair  <= pair_nx;
						state <= load_next ? S_RD_U : S_PUSH_LO;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

/* yuv_rgb_top.sv */
`timescale 1ns/1ps

module yuv_rgb_top
	import yuv_mem_pkg::*, yuv_color_pkg::*;
#(
	parameter int IMG_WIDTH  = 12,
	parameter int IMG_HEIGHT = 2
) (
	input  logic                  Clock,
	input  logic                  Resetn,
	input  logic                  cfg_write,
	input  logic [CFG_ADDR_W-1:0] cfg_addr,
	input  logic [ADDR_W-1:0]     cfg_wdata,
	output logic [ADDR_W-1:0]     cfg_rdata,
	input  logic                  start,
	output logic                  busy,
	output logic                  done,
	output logic [ADDR_W-1:0]     sram_address,
	input  logic [DATA_W-1:0]     sram_read_data,
	output logic [DATA_W-1:0]     sram_write_data,
	output logic                  sram_we_n
);

	logic [ADDR_W-1:0] y_base;
	logic [ADDR_W-1:0] u_base;
	logic [ADDR_W-1:0] v_base;
	logic [ADDR_W-1:0] rgb_base;
	logic              run;
	logic              frame_end;
	logic              u_prime;
	logic              u_push;
	logic              v_prime;
	logic              v_push;
	logic [PIX_W-1:0]  chroma_sample_u;
	logic [PIX_W-1:0]  chroma_sample_v;
	logic [PIX_W-1:0]  u_even;
	logic [PIX_W-1:0]  u_odd;
	logic [PIX_W-1:0]  v_even;
	logic [PIX_W-1:0]  v_odd;
	logic              conv_in_valid;
	logic [PIX_W-1:0]  y_in;
	logic [PIX_W-1:0]  conv_u;
	logic [PIX_W-1:0]  conv_v;
	logic [PIX_W-1:0]  r_out;
	logic [PIX_W-1:0]  g_out;
	logic [PIX_W-1:0]  b_out;
	logic              conv_out_valid;

	yuv_regs #(
		.IMG_WIDTH  (IMG_WIDTH),
		.IMG_HEIGHT (IMG_HEIGHT)
	) i_regs (
		.Clock, .Resetn, .cfg_write, .cfg_addr, .cfg_wdata, .start, .frame_end,
		.cfg_rdata, .y_base, .u_base, .v_base, .rgb_base, .run, .busy, .done
	);

	m1_sequencer #(
		.IMG_WIDTH  (IMG_WIDTH),
		.IMG_HEIGHT (IMG_HEIGHT)
	) i_seq (
		.Clock, .Resetn, .run, .y_base, .u_base, .v_base, .rgb_base, .sram_read_data,
		.r_out, .g_out, .b_out, .conv_out_valid, .u_even, .u_odd, .v_even, .v_odd,
		.sram_address, .sram_write_data, .sram_we_n, .frame_end,
		.u_prime, .u_push, .v_prime, .v_push, .chroma_sample_u, .chroma_sample_v,
		.conv_in_valid, .y_in, .conv_u, .conv_v
	);

	chroma_upsampler i_up_u (
		.Clock, .Resetn,
		.prime     (u_prime),
		.push      (u_push),
		.sample_in (chroma_sample_u),
		.even_out  (u_even),
		.odd_out   (u_odd)
	);

	chroma_upsampler i_up_v (
		.Clock, .Resetn,
		.prime     (v_prime),
		.push      (v_push),
		.sample_in (chroma_sample_v),
		.even_out  (v_even),
		.odd_out   (v_odd)
	);

	csc_unit i_csc (
		.Clock, .Resetn, .conv_in_valid, .y_in,
		.u_in (conv_u),
		.v_in (conv_v),
		.r_out, .g_out, .b_out, .conv_out_valid
	);

endmodule

/* tb_sram_model.sv */
`timescale 1ns/1ps

module tb_sram_model
	import yuv_mem_pkg::*;
(
	input  logic              Clock,
	input  logic [ADDR_W-1:0] address,
	input  logic [DATA_W-1:0] write_data,
	input  logic              we_n,
	output logic [DATA_W-1:0] read_data
);

	logic [DATA_W-1:0] mem [2**ADDR_W];

	// registered read path, one stage per cycle of latency
	logic [DATA_W-1:0] rd_pipe [SRAM_RD_LAT];

	always @(posedge Clock) begin
		if (!we_n)
			mem[address] <= write_data;
		rd_pipe[0] <= mem[address];
		for (int i = 1; i < SRAM_RD_LAT; i++)
			rd_pipe[i] <= rd_pipe[i-1];
	end

	assign read_data = rd_pipe[SRAM_RD_LAT-1];

	// backdoor access, no bus cycles
	task automatic load_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		mem[addr] <= data;
	endtask

	task automatic peek_word(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
		data = mem[addr];
	endtask

endmodule

/* yuv_rgb_sva.sv */
`timescale 1ns/1ps

module yuv_rgb_sva
	import yuv_mem_pkg::*;
(
	input logic              Clock,
	input logic              Resetn,
	input logic              sram_we_n,
	input logic [ADDR_W-1:0] sram_address,
	input logic [ADDR_W-1:0] rgb_base,
	input logic [ADDR_W-1:0] rgb_end,
	input logic              busy,
	input logic              done
);

	// writes stay inside the RGB region
	a_write_range: assert property (@(posedge Clock) disable iff (!Resetn)
		!sram_we_n |-> (sram_address >= rgb_base) && (sram_address < rgb_end))
		else $error("write to 0x%0h outside the RGB region", sram_address);

	a_done_pulse: assert property (@(posedge Clock) disable iff (!Resetn)
		done |=> !done)
		else $error("done held for more than one cycle");

	a_busy_after_done: assert property (@(posedge Clock) disable iff (!Resetn)
		done |=> !busy)
		else $error("busy still high in the cycle after done");

endmodule

bind yuv_rgb_top yuv_rgb_sva i_sva (
	.Clock,
	.Resetn,
	.sram_we_n,
	.sram_address,
	.rgb_base,
	.rgb_end (i_regs.rgb_end),
	.busy,
	.done
);

/* tb_yuv_rgb.sv */
`timescale 1ns/1ps

module tb_yuv_rgb
	import yuv_mem_pkg::*, yuv_color_pkg::*;
();

	localparam int IMG_WIDTH    = 12;
	localparam int IMG_HEIGHT   = 2;
	localparam int PAIRS        = IMG_WIDTH / 2;
	localparam int Y_WORDS      = IMG_WIDTH / 2;
	localparam int C_WORDS      = IMG_WIDTH / 4;
	localparam int RGB_WORDS    = PAIRS * 3 * IMG_HEIGHT;
	localparam int N_FRAMES     = 5;
	localparam int DONE_TIMEOUT = 5000;
	localparam int IDLE_CYCLES  = 40;
	localparam logic [DATA_W-1:0] MARKER = 16'hc35a;

	localparam int PAT_CONST   = 0;
	localparam int PAT_RAMP    = 1;
	localparam int PAT_RANDOM  = 2;
	localparam int PAT_EXTREME = 3;
	localparam int PAT_ALT     = 4;

	// one frame per entry: image pattern and the four base addresses
	localparam int PATTERN [N_FRAMES] = '{PAT_CONST, PAT_RAMP, PAT_RANDOM, PAT_EXTREME, PAT_ALT};
	localparam logic [ADDR_W-1:0] Y_BASES [N_FRAMES] =
		'{18'h00000, 18'h01000, 18'h3f000, 18'h02030, 18'h20000};
	localparam logic [ADDR_W-1:0] U_BASES [N_FRAMES] =
		'{18'h00100, 18'h01040, 18'h3f100, 18'h02040, 18'h20010};
	localparam logic [ADDR_W-1:0] V_BASES [N_FRAMES] =
		'{18'h00200, 18'h01080, 18'h3f200, 18'h02050, 18'h20020};
	localparam logic [ADDR_W-1:0] RGB_BASES [N_FRAMES] =
		'{18'h00300, 18'h010c0, 18'h3f300, 18'h02000, 18'h20030};

	logic                  Clock = 1'b0;
	logic                  Resetn;
	logic                  cfg_write;
	logic [CFG_ADDR_W-1:0] cfg_addr;
	logic [ADDR_W-1:0]     cfg_wdata;
	logic [ADDR_W-1:0]     cfg_rdata;
	logic                  start;
	logic                  busy;
	logic                  done;
	logic [ADDR_W-1:0]     sram_address;
	logic [DATA_W-1:0]     sram_read_data;
	logic [DATA_W-1:0]     sram_write_data;
	logic                  sram_we_n;

	int y_img [IMG_HEIGHT][IMG_WIDTH];
	int u_img [IMG_HEIGHT][PAIRS];
	int v_img [IMG_HEIGHT][PAIRS];
	int done_count;

	yuv_rgb_top #(
		.IMG_WIDTH  (IMG_WIDTH),
		.IMG_HEIGHT (IMG_HEIGHT)
	) i_dut (
		.Clock, .Resetn, .cfg_write, .cfg_addr, .cfg_wdata, .cfg_rdata,
		.start, .busy, .done,
		.sram_address, .sram_read_data, .sram_write_data, .sram_we_n
	);

	tb_sram_model i_sram (
		.Clock,
		.address    (sram_address),
		.write_data (sram_write_data),
		.we_n       (sram_we_n),
		.read_data  (sram_read_data)
	);

	always #4 Clock = ~Clock;

	always @(posedge Clock or negedge Resetn) begin
		if (!Resetn)
			done_count <= 0;
		else if (done)
			done_count <= done_count + 1;
	end

	task automatic stop_with_fail();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
			stop_with_fail();
		end
	endtask

	function automatic logic [ADDR_W-1:0] addr_at(input logic [ADDR_W-1:0] base, input int off);
		return base + ADDR_W'(off);
	endfunction

	function automatic logic [DATA_W-1:0] pack2(input int hi, input int lo);
		return {hi[7:0], lo[7:0]};
	endfunction

	function automatic int sat_byte(input int v);
		if (v < 0)
			return 0;
		if (v > 255)
			return 255;
		return v;
	endfunction

	// chroma sample with the row edges clamped
	function automatic int chroma(input int plane, input int r, input int k);
		int kc;
		kc = (k < 0) ? 0 : ((k > PAIRS - 1) ? PAIRS - 1 : k);
		return (plane == 0) ? u_img[r][kc] : v_img[r][kc];
	endfunction

	function automatic int upsampled(input int plane, input int r, input int j);
		int k;
		int acc;
		k = j / 2;
		if (j % 2 == 0)
			return chroma(plane, r, k);
		acc = TAP_0 * (chroma(plane, r, k - 2) + chroma(plane, r, k + 3))
			+ TAP_1 * (chroma(plane, r, k - 1) + chroma(plane, r, k + 2))
			+ TAP_2 * (chroma(plane, r, k) + chroma(plane, r, k + 1))
			+ FILT_ROUND;
		return sat_byte(acc >>> FILT_SHIFT);
	endfunction

	// expected {R, G, B} of one pixel
	function automatic logic [23:0] ref_pixel(input int r, input int j);
		int yd;
		int ud;
		int vd;
		int rr;
		int gg;
		int bb;
		yd = y_img[r][j] - Y_OFFSET;
		ud = upsampled(0, r, j) - UV_OFFSET;
		vd = upsampled(1, r, j) - UV_OFFSET;
		rr = sat_byte((C_Y * yd + C_RV * vd) >>> CSC_SHIFT);
		gg = sat_byte((C_Y * yd - C_GU * ud - C_GV * vd) >>> CSC_SHIFT);
		bb = sat_byte((C_Y * yd + C_BU * ud) >>> CSC_SHIFT);
		return {rr[7:0], gg[7:0], bb[7:0]};
	endfunction

	task automatic build_image(input int pat);
		for (int r = 0; r < IMG_HEIGHT; r++) begin
			for (int j = 0; j < IMG_WIDTH; j++) begin
				case (pat)
					PAT_CONST:   y_img[r][j] = 100;
					PAT_RAMP:    y_img[r][j] = 16 + 20 * j;
					PAT_RANDOM:  y_img[r][j] = $urandom & 255;
					PAT_EXTREME: y_img[r][j] = ((j + r) % 3 == 0) ? 0 : 255;
					default:     y_img[r][j] = (j % 2 == 1) ? 255 : 0;
				endcase
			end
			for (int k = 0; k < PAIRS; k++) begin
				case (pat)
					PAT_CONST: begin
						u_img[r][k] = 90;
						v_img[r][k] = 170;
					end
					PAT_RAMP: begin
						u_img[r][k] = 40 * k + 10 * r;
						v_img[r][k] = 250 - 40 * k;
					end
					PAT_RANDOM: begin
						u_img[r][k] = $urandom & 255;
						v_img[r][k] = $urandom & 255;
					end
					PAT_EXTREME: begin
						u_img[r][k] = (k % 4 < 2) ? 255 : 0;
						v_img[r][k] = 255 - u_img[r][k];
					end
					default: begin
						u_img[r][k] = (k % 2 == 1) ? 255 : 0;
						v_img[r][k] = (k % 2 == 1) ? 0 : 255;
					end
				endcase
			end
		end
	endtask

	task automatic load_frame(input int f);
		for (int r = 0; r < IMG_HEIGHT; r++) begin
			for (int p = 0; p < Y_WORDS; p++)
				i_sram.load_word(addr_at(Y_BASES[f], r * Y_WORDS + p),
					pack2(y_img[r][2*p], y_img[r][2*p+1]));
			for (int m = 0; m < C_WORDS; m++) begin
				i_sram.load_word(addr_at(U_BASES[f], r * C_WORDS + m),
					pack2(u_img[r][2*m], u_img[r][2*m+1]));
				i_sram.load_word(addr_at(V_BASES[f], r * C_WORDS + m),
					pack2(v_img[r][2*m], v_img[r][2*m+1]));
			end
		end
		// RGB region plus one guard word
		for (int i = 0; i <= RGB_WORDS; i++)
			i_sram.load_word(addr_at(RGB_BASES[f], i), MARKER);
	endtask

	task automatic write_reg(input logic [CFG_ADDR_W-1:0] idx, input logic [ADDR_W-1:0] val);
		@(posedge Clock);
		cfg_write <= 1'b1;
		cfg_addr  <= idx;
		cfg_wdata <= val;
		@(posedge Clock);
		cfg_write <= 1'b0;
	endtask

	task automatic read_reg(input logic [CFG_ADDR_W-1:0] idx, output logic [ADDR_W-1:0] val);
		@(posedge Clock);
		cfg_addr <= idx;
		@(negedge Clock);
		val = cfg_rdata;
	endtask

	task automatic check_regs(input logic [ADDR_W-1:0] yb, input logic [ADDR_W-1:0] ub,
			input logic [ADDR_W-1:0] vb, input logic [ADDR_W-1:0] rb);
		logic [ADDR_W-1:0] val;
		read_reg(REG_Y_BASE, val);
		check_value("y_base", 32'(val), 32'(yb));
		read_reg(REG_U_BASE, val);
		check_value("u_base", 32'(val), 32'(ub));
		read_reg(REG_V_BASE, val);
		check_value("v_base", 32'(val), 32'(vb));
		read_reg(REG_RGB_BASE, val);
		check_value("rgb_base", 32'(val), 32'(rb));
	endtask

	task automatic pulse_start();
		@(posedge Clock);
		start <= 1'b1;
		@(posedge Clock);
		start <= 1'b0;
	endtask

	task automatic check_memory(input int f);
		logic [23:0]       e;
		logic [23:0]       o;
		logic [DATA_W-1:0] got;
		int                base;
		for (int r = 0; r < IMG_HEIGHT; r++) begin
			for (int p = 0; p < PAIRS; p++) begin
				e    = ref_pixel(r, 2 * p);
				o    = ref_pixel(r, 2 * p + 1);
				base = (r * PAIRS + p) * 3;
				i_sram.peek_word(addr_at(RGB_BASES[f], base), got);
				check_value($sformatf("rgb[%0d]", base), 32'(got), 32'(e[23:8]));
				i_sram.peek_word(addr_at(RGB_BASES[f], base + 1), got);
				check_value($sformatf("rgb[%0d]", base + 1), 32'(got), 32'({e[7:0], o[23:16]}));
				i_sram.peek_word(addr_at(RGB_BASES[f], base + 2), got);
				check_value($sformatf("rgb[%0d]", base + 2), 32'(got), 32'(o[15:0]));
			end
			for (int p = 0; p < Y_WORDS; p++) begin
				i_sram.peek_word(addr_at(Y_BASES[f], r * Y_WORDS + p), got);
				check_value("y region", 32'(got), 32'(pack2(y_img[r][2*p], y_img[r][2*p+1])));
			end
			for (int m = 0; m < C_WORDS; m++) begin
				i_sram.peek_word(addr_at(U_BASES[f], r * C_WORDS + m), got);
				check_value("u region", 32'(got), 32'(pack2(u_img[r][2*m], u_img[r][2*m+1])));
				i_sram.peek_word(addr_at(V_BASES[f], r * C_WORDS + m), got);
				check_value("v region", 32'(got), 32'(pack2(v_img[r][2*m], v_img[r][2*m+1])));
			end
		end
		i_sram.peek_word(addr_at(RGB_BASES[f], RGB_WORDS), got);
		check_value("guard word", 32'(got), 32'(MARKER));
	endtask

	task automatic run_frame(input int f);
		logic seen;
		build_image(PATTERN[f]);
		load_frame(f);
		write_reg(REG_Y_BASE, Y_BASES[f]);
		write_reg(REG_U_BASE, U_BASES[f]);
		write_reg(REG_V_BASE, V_BASES[f]);
		write_reg(REG_RGB_BASE, RGB_BASES[f]);
		check_regs(Y_BASES[f], U_BASES[f], V_BASES[f], RGB_BASES[f]);
		pulse_start();
		@(negedge Clock);
		check_value("busy", 32'(busy), 32'd1);
		// second start lands after the last write, while the FSM heads back to idle
		seen = 1'b0;
		for (int cyc = 0; cyc < DONE_TIMEOUT && !seen; cyc++) begin
			@(negedge Clock);
			check_value("busy", 32'(busy), 32'd1);
			if (!sram_we_n && sram_address == addr_at(RGB_BASES[f], RGB_WORDS - 1))
				seen = 1'b1;
		end
		if (!seen) begin
			$display("frame %0d: no final RGB write within %0d cycles", f, DONE_TIMEOUT);
			stop_with_fail();
		end
		pulse_start();
		seen = 1'b0;
		for (int cyc = 0; cyc < DONE_TIMEOUT && !seen; cyc++) begin
			@(negedge Clock);
			if (done)
				seen = 1'b1;
			else
				check_value("busy", 32'(busy), 32'd1);
		end
		if (!seen) begin
			$display("frame %0d: done did not arrive within %0d cycles", f, DONE_TIMEOUT);
			stop_with_fail();
		end
		for (int cyc = 0; cyc < IDLE_CYCLES; cyc++) begin
			@(negedge Clock);
			check_value("busy", 32'(busy), 32'd0);
			check_value("done", 32'(done), 32'd0);
			check_value("sram_we_n", 32'(sram_we_n), 32'd1);
		end
		check_value("done count", 32'(done_count), 32'(f + 1));
		check_memory(f);
	endtask

	initial begin
		void'($urandom(53544));
		Resetn    <= 1'b0;
		cfg_write <= 1'b0;
		cfg_addr  <= '0;
		cfg_wdata <= '0;
		start     <= 1'b0;
		repeat (8) @(posedge Clock);
		Resetn <= 1'b1;
		@(negedge Clock);
		check_value("sram_we_n", 32'(sram_we_n), 32'd1);
		check_value("busy", 32'(busy), 32'd0);
		check_value("done", 32'(done), 32'd0);
		check_regs('0, '0, '0, '0);
		for (int f = 0; f < N_FRAMES; f++)
			run_frame(f);
		check_value("done count", 32'(done_count), 32'(N_FRAMES));
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

/* verilog.f */
yuv_mem_pkg.sv
yuv_color_pkg.sv
yuv_regs.sv
chroma_upsampler.sv
csc_unit.sv
m1_sequencer.sv
yuv_rgb_top.sv
tb_sram_model.sv
yuv_rgb_sva.sv
tb_yuv_rgb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module tb_yuv_rgb \
	-f verilog.f -o tb_yuv_rgb; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_yuv_rgb)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q "^Simulation finished: PASS$"; then
	exit 0
fi
exit 1
